// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
TOP       = mailbox_bridge_tb
FILELIST  = mailbox_bridge.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: mailbox_bridge.f
source/mailbox_pkg.sv
source/signal_synchronizer.sv
source/jtag_mailbox_port.sv
source/mailbox_endpoint.sv
source/wb_mailbox_controller.sv
source/mailbox_bridge_top.sv
sim/mailbox_bridge_tb.sv

// File: sim/mailbox_bridge_tb.sv
/* Testbench for the debug mailbox, runs the operations of sim/mailbox_input.txt
   against both the JTAG port and the Wishbone bus and reports the error counts. */
`timescale 1ns/1ps

module mailbox_bridge_tb;

	localparam int MAX_OPS      = 64;
	localparam int ACK_TIMEOUT  = 20;
	localparam int POLL_TIMEOUT = 50;
	// Operation codes of the data file
	localparam logic [31:0] OP_END     = 32'h0;
	localparam logic [31:0] OP_JWRITE  = 32'h1;
	localparam logic [31:0] OP_JREAD   = 32'h2;
	localparam logic [31:0] OP_WBWRITE = 32'h3;
	localparam logic [31:0] OP_WBREAD  = 32'h4;
	localparam logic [31:0] OP_IDLE    = 32'h5;
	localparam logic [31:0] OP_POLL    = 32'h6;

	logic                  rvx_port_02;
	logic                  rvx_port_12;
	mailbox_pkg::inst_t    jtag_inst;
	logic                  jtag_wr_en;
	mailbox_pkg::word_t    jtag_wr_data;
	logic                  jtag_rd_en;
	mailbox_pkg::word_t    jtag_rd_data;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	mailbox_pkg::wb_addr_t wb_adr;
	mailbox_pkg::word_t    wb_dat_w;
	mailbox_pkg::word_t    wb_dat_r;
	logic                  wb_ack;

	// Four words per operation in the order op, arg, data, expected
	logic [31:0] ops [4*MAX_OPS];
	int mismatch_count = 0;
	int timeout_count  = 0;
	int other_count    = 0;
	int cycle_count    = 0;

	mailbox_bridge_top i_mailbox_bridge_top (.rvx_port_02, .rvx_port_12, .jtag_inst,
		.jtag_wr_en, .jtag_wr_data, .jtag_rd_en, .jtag_rd_data, .wb_cyc, .wb_stb,
		.wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack);

	// 100 ns clock
	always
	begin
		#50;
		rvx_port_02 = ~rvx_port_02;
	end

	always @(posedge rvx_port_02)
		cycle_count++;

	// ********************
	// Helpers
	// ********************

	// Inputs change 1 ns after the rising edge
	task automatic next_slot();
		@(posedge rvx_port_02);
		#1;
	endtask

	task automatic compare_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("mismatch at %0t: %s expected %h, actual %h", $time, name, expected, actual);
			mismatch_count++;
		end
	endtask

	// One-cycle write pulse on the register port
	task automatic jtag_write(input mailbox_pkg::inst_t inst, input mailbox_pkg::word_t data);
		next_slot();
		jtag_inst    = inst;
		jtag_wr_data = data;
		jtag_wr_en   = 1'b1;
		next_slot();
		jtag_wr_en = 1'b0;
	endtask

	// Read data is combinational and sampled mid-cycle
	task automatic jtag_read(input mailbox_pkg::inst_t inst, input logic rd_en,
		input mailbox_pkg::word_t expected);
		next_slot();
		jtag_inst  = inst;
		jtag_rd_en = rd_en;
		@(negedge rvx_port_02);
		compare_word("jtag_rd_data", expected, jtag_rd_data);
		next_slot();
		jtag_rd_en = 1'b0;
	endtask

	// Classic single access held until ack
	task automatic wb_access(input logic we, input mailbox_pkg::wb_addr_t adr,
		input mailbox_pkg::word_t data, output mailbox_pkg::word_t rd);
		int waited;
		rd     = '0;
		waited = 0;
		next_slot();
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = data;
		@(negedge rvx_port_02);
		while (!wb_ack && (waited < ACK_TIMEOUT))
		begin
			@(negedge rvx_port_02);
			waited++;
		end
		if (wb_ack)
			rd = wb_dat_r;
		else
		begin
			$display("timeout at %0t: no wb_ack for offset %h", $time, adr);
			timeout_count++;
		end
		next_slot();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		// Ack lasts a single cycle
		compare_word("wb_ack", '0, {31'b0, wb_ack});
	endtask

	// Repeat status reads until the masked bits match
	task automatic poll_status(input mailbox_pkg::word_t mask, input mailbox_pkg::word_t expected);
		mailbox_pkg::word_t value;
		int start;
		int prior;
		start = cycle_count;
		prior = timeout_count;
		wb_access(1'b0, mailbox_pkg::REG_STATUS, '0, value);
		while (((value & mask) != expected) && ((cycle_count - start) < POLL_TIMEOUT)
			&& (timeout_count == prior))
			wb_access(1'b0, mailbox_pkg::REG_STATUS, '0, value);
		if (((value & mask) != expected) && (timeout_count == prior))
		begin
			$display("timeout at %0t: status bits %h never reached %h", $time, mask, expected);
			timeout_count++;
		end
	endtask

	// ********************
	// Main sequence
	// ********************
	initial
	begin
		int op_index;
		int prior;
		logic [31:0] op;
		logic [31:0] arg;
		logic [31:0] data;
		logic [31:0] expected;
		mailbox_pkg::word_t rd_value;
		rvx_port_02  = 1'b0;
		rvx_port_12  = 1'b0;
		jtag_inst    = '0;
		jtag_wr_en   = 1'b0;
		jtag_wr_data = '0;
		jtag_rd_en   = 1'b0;
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_we        = 1'b0;
		wb_adr       = '0;
		wb_dat_w     = '0;
		// Unfilled entries read as the end operation
		for (int i = 0; i < 4*MAX_OPS; i++)
			ops[i] = '0;
		$readmemh("sim/mailbox_input.txt", ops);
		repeat (5) @(posedge rvx_port_02);
		#1;
		rvx_port_12 = 1'b1;
		// Bus ack is quiet straight out of reset
		compare_word("wb_ack", '0, {31'b0, wb_ack});
		op_index = 0;
		while ((op_index < MAX_OPS) && (ops[4*op_index] != OP_END) && (timeout_count == 0))
		begin
			op       = ops[4*op_index];
			arg      = ops[4*op_index+1];
			data     = ops[4*op_index+2];
			expected = ops[4*op_index+3];
			case (op)
				OP_JWRITE:  jtag_write(arg[7:0], data);
				OP_JREAD:   jtag_read(arg[7:0], data[0], expected);
				OP_WBWRITE: wb_access(1'b1, arg[3:0], data, rd_value);
				OP_WBREAD:
				begin
					prior = timeout_count;
					wb_access(1'b0, arg[3:0], '0, rd_value);
					if (timeout_count == prior)
						compare_word("wb_dat_r", expected, rd_value);
				end
				OP_IDLE:    repeat (arg) @(posedge rvx_port_02);
				OP_POLL:    poll_status(data, expected);
				default:
				begin
					$display("unknown operation %h in entry %0d of the data file", op, op_index);
					other_count++;
				end
			endcase
			op_index++;
		end
		if (op_index == 0)
		begin
			$display("no operations found in the data file");
			other_count++;
		end
		$display("errors: %0d mismatches, %0d timeouts, %0d other", mismatch_count,
			timeout_count, other_count);
		if ((mismatch_count == 0) && (timeout_count == 0) && (other_count == 0))
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: sim/mailbox_input.txt
// Columns in hex: op arg data expected
// op 1 jwrite, 2 jread (data = rd_en), 3 wbwrite, 4 wbread, 5 idle, 6 poll status (data = mask)
2 01 0 00000000
4 0 0 00000000
2 03 0 00000000
2 04 0 00000000
// First request, the second write while busy is dropped
1 01 cafe0001 0
6 0 1 1
1 01 dead0002 0
2 01 0 1
4 4 0 cafe0001
5 4 0 0
2 01 0 0
2 03 0 1
// First response
3 8 beef0001 0
5 3 0 0
2 04 0 1
4 0 0 2
2 02 1 beef0001
6 0 2 0
// Second round trip
1 01 cafe0003 0
6 0 1 1
4 4 0 cafe0003
3 8 beef0003 0
5 3 0 0
2 02 1 beef0003
6 0 2 0
// Third round trip
1 01 cafe0004 0
6 0 1 1
4 4 0 cafe0004
3 8 beef0004 0
5 3 0 0
2 02 1 beef0004
6 0 2 0
2 03 0 3
2 04 0 3
0 0 0 0

// File: source/jtag_mailbox_port.sv
/* JTAG-side mailbox registers: posts request words, acknowledges responses and
   returns register reads selected by the current instruction. */
`timescale 1ns/1ps

module jtag_mailbox_port
(
	input  logic                 rvx_port_02,
	input  logic                 rvx_port_12,

	// Register port from the TAP
	input  mailbox_pkg::inst_t   jtag_inst,
	input  logic                 jtag_wr_en,
	input  mailbox_pkg::word_t   jtag_wr_data,
	input  logic                 jtag_rd_en,
	output mailbox_pkg::word_t   jtag_rd_data,

	// Request channel
	output logic                 req_toggle,
	output mailbox_pkg::word_t   req_data,
	input  logic                 req_ack_sync,
	input  mailbox_pkg::count_t  req_count_sync,

	// Response channel
	input  logic                 resp_toggle_sync,
	input  mailbox_pkg::word_t   resp_data_sync,
	input  mailbox_pkg::count_t  resp_count_sync,
	output logic                 resp_ack_toggle
);

	logic port_idle;
	logic resp_new;

	// ********************
	// Request side
	// ********************

	// Idle once the endpoint has echoed our toggle back
	assign port_idle = (req_toggle == req_ack_sync);

	always_ff @(posedge rvx_port_02 or negedge rvx_port_12)
	begin
		if (!rvx_port_12)
		begin
			req_toggle <= 1'b0;
			req_data   <= '0;
		end
		else if (port_idle && jtag_wr_en && (jtag_inst == mailbox_pkg::INST_REQUEST))
		begin
			// Word and toggle change together and cross as one group
			req_toggle <= ~req_toggle;
			req_data   <= jtag_wr_data;
		end
	end

	// ********************
	// Response side
	// ********************

	// Endpoint toggle ahead of ours means an unread response
	assign resp_new = (resp_toggle_sync != resp_ack_toggle);

	always_ff @(posedge rvx_port_02 or negedge rvx_port_12)
	begin
		if (!rvx_port_12)
			resp_ack_toggle <= 1'b0;
		else if (resp_new && jtag_rd_en && (jtag_inst == mailbox_pkg::INST_RESPONSE))
			resp_ack_toggle <= ~resp_ack_toggle;
	end

	// Combinational read mux so the TAP sees the data at once
	always_comb
	begin
		jtag_rd_data = '0;
		case (jtag_inst)
			mailbox_pkg::INST_REQUEST:
				jtag_rd_data = {31'b0, ~port_idle};
			mailbox_pkg::INST_RESPONSE:
				jtag_rd_data = resp_data_sync;
			mailbox_pkg::INST_NUM_REQUEST:
				jtag_rd_data = req_count_sync;
			mailbox_pkg::INST_NUM_RESPONSE:
				jtag_rd_data = resp_count_sync;
			default:
				jtag_rd_data = '0;
		endcase
	end

endmodule

// File: source/mailbox_bridge_top.sv
/* Debug mailbox between a JTAG register port and a Wishbone classic bus.
   Connects the JTAG port, the crossing synchronizers, the endpoint and the bus controller. */
`timescale 1ns/1ps

module mailbox_bridge_top
(
	input  logic                   rvx_port_02,
	input  logic                   rvx_port_12,
	input  mailbox_pkg::inst_t     jtag_inst,
	input  logic                   jtag_wr_en,
	input  mailbox_pkg::word_t     jtag_wr_data,
	input  logic                   jtag_rd_en,
	output mailbox_pkg::word_t     jtag_rd_data,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  mailbox_pkg::wb_addr_t  wb_adr,
	input  mailbox_pkg::word_t     wb_dat_w,
	output mailbox_pkg::word_t     wb_dat_r,
	output logic                   wb_ack
);

	// JTAG port outputs and their synchronized copies
	logic req_toggle, resp_ack_toggle;
	mailbox_pkg::word_t req_data;
	logic [mailbox_pkg::SYNC_WIDTH-1:0] to_ep_sync, ack_sync, resp_sync;
	// Endpoint outputs
	logic req_ack_toggle, resp_toggle;
	mailbox_pkg::count_t req_count, resp_count;
	mailbox_pkg::word_t resp_data;
	// Controller to endpoint
	logic take_req, post_resp, req_pending, resp_unconsumed;
	mailbox_pkg::word_t post_data, req_word;

	jtag_mailbox_port i_jtag_mailbox_port (
		.rvx_port_02, .rvx_port_12, .jtag_inst, .jtag_wr_en, .jtag_wr_data,
		.jtag_rd_en, .jtag_rd_data, .req_toggle, .req_data,
		.req_ack_sync(ack_sync[32]), .req_count_sync(ack_sync[31:0]),
		.resp_toggle_sync(resp_sync[64]), .resp_data_sync(resp_sync[63:32]),
		.resp_count_sync(resp_sync[31:0]), .resp_ack_toggle);

	// ********************
	// Crossings
	// ********************
	// Group toward the endpoint with the upper 31 bits tied low
	signal_synchronizer i_sync_to_endpoint (.rvx_port_02, .rvx_port_12,
		.async_value({31'b0, resp_ack_toggle, req_toggle, req_data}), .sync_value(to_ep_sync));
	// Two groups carry the 98 bits toward the JTAG port
	signal_synchronizer i_sync_req_ack (.rvx_port_02, .rvx_port_12,
		.async_value({32'b0, req_ack_toggle, req_count}), .sync_value(ack_sync));
	signal_synchronizer i_sync_resp (.rvx_port_02, .rvx_port_12,
		.async_value({resp_toggle, resp_data, resp_count}), .sync_value(resp_sync));

	mailbox_endpoint i_mailbox_endpoint (
		.rvx_port_02, .rvx_port_12, .req_toggle_sync(to_ep_sync[32]),
		.req_data_sync(to_ep_sync[31:0]), .req_ack_toggle, .req_count, .resp_toggle,
		.resp_data, .resp_count, .resp_ack_sync(to_ep_sync[33]), .take_req, .post_resp,
		.post_data, .req_pending, .resp_unconsumed, .req_word);

	wb_mailbox_controller i_wb_mailbox_controller (
		.rvx_port_02, .rvx_port_12, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
		.wb_dat_r, .wb_ack, .take_req, .post_resp, .post_data, .req_pending,
		.resp_unconsumed, .req_word);

endmodule

// File: source/mailbox_endpoint.sv
/* System-side mailbox state: pending flags from the toggle compares, the response word,
   both handshake toggles and both transfer counters. Driven by the bus controller strobes. */
`timescale 1ns/1ps

module mailbox_endpoint
(
	input  logic                 rvx_port_02,
	input  logic                 rvx_port_12,

	// Request channel from the JTAG port
	input  logic                 req_toggle_sync,
	input  mailbox_pkg::word_t   req_data_sync,
	output logic                 req_ack_toggle,
	output mailbox_pkg::count_t  req_count,

	// Response channel to the JTAG port
	output logic                 resp_toggle,
	output mailbox_pkg::word_t   resp_data,
	output mailbox_pkg::count_t  resp_count,
	input  logic                 resp_ack_sync,

	// Bus controller side
	input  logic                 take_req,
	input  logic                 post_resp,
	input  mailbox_pkg::word_t   post_data,
	output logic                 req_pending,
	output logic                 resp_unconsumed,
	output mailbox_pkg::word_t   req_word
);

	// Toggles differ while a word sits in the mailbox
	assign req_pending     = (req_toggle_sync != req_ack_toggle);
	assign resp_unconsumed = (resp_toggle != resp_ack_sync);

	// Port holds its word until acknowledged, so it reads straight through
	assign req_word = req_data_sync;

	// ********************
	// Request acknowledge
	// ********************
	always_ff @(posedge rvx_port_02 or negedge rvx_port_12)
	begin
		if (!rvx_port_12)
		begin
			req_ack_toggle <= 1'b0;
			req_count      <= '0;
		end
		else if (take_req && req_pending)
		begin
			req_ack_toggle <= ~req_ack_toggle;
			req_count      <= req_count + 1'b1;
		end
	end

	// ********************
	// Response post
	// ********************
	always_ff @(posedge rvx_port_02 or negedge rvx_port_12)
	begin
		if (!rvx_port_12)
		begin
			resp_toggle <= 1'b0;
			resp_data   <= '0;
			resp_count  <= '0;
		end
		else if (post_resp)
		begin
			resp_data <= post_data;
			// Unread response only gets its word replaced
			if (!resp_unconsumed)
			begin
				resp_toggle <= ~resp_toggle;
				resp_count  <= resp_count + 1'b1;
			end
		end
	end

endmodule

// File: source/mailbox_pkg.sv
/* Widths, JTAG instruction codes and the Wishbone register map of the debug mailbox.
   Compiled first; the other files refer to it by scoped names. */
package mailbox_pkg;

	// ********************
	// Widths
	// ********************
	localparam int WORD_WIDTH    = 32;
	localparam int INST_WIDTH    = 8;
	localparam int WB_ADDR_WIDTH = 4;
	localparam int COUNT_WIDTH   = 32;
	// Toggle, data word and count word of one crossing group
	localparam int SYNC_WIDTH    = 65;
	// Flop depth of every synchronizer
	localparam int SYNC_STAGES   = 2;

	typedef logic [WORD_WIDTH-1:0]    word_t;
	typedef logic [INST_WIDTH-1:0]    inst_t;
	typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;
	typedef logic [COUNT_WIDTH-1:0]   count_t;

	// ********************
	// JTAG instructions
	// ********************
	localparam inst_t INST_REQUEST      = 8'h01;
	localparam inst_t INST_RESPONSE     = 8'h02;
	localparam inst_t INST_NUM_REQUEST  = 8'h03;
	localparam inst_t INST_NUM_RESPONSE = 8'h04;

	// Wishbone byte offsets
	// Status bit 0 is request pending, bit 1 is response unconsumed
	localparam wb_addr_t REG_STATUS    = 4'h0;
	localparam wb_addr_t REG_REQ_DATA  = 4'h4;
	localparam wb_addr_t REG_RESP_DATA = 4'h8;

	// Bus controller states
	typedef enum logic {
		wb_idle,
		wb_ack
	} wb_state_t;

endpackage

// File: source/signal_synchronizer.sv
/* Flop chain that brings a 65-bit group of toggles and data words into the local clock.
   A change at the input shows at the output after SYNC_STAGES edges. */
`timescale 1ns/1ps

module signal_synchronizer
(
	input  logic                                rvx_port_02,
	input  logic                                rvx_port_12,
	input  logic [mailbox_pkg::SYNC_WIDTH-1:0]  async_value,
	output logic [mailbox_pkg::SYNC_WIDTH-1:0]  sync_value
);

	// One entry per flop stage with entry 0 facing the foreign domain
	logic [mailbox_pkg::SYNC_WIDTH-1:0] stage [mailbox_pkg::SYNC_STAGES];

	always_ff @(posedge rvx_port_02 or negedge rvx_port_12)
	begin
		if (!rvx_port_12)
		begin
			for (int i = 0; i < mailbox_pkg::SYNC_STAGES; i++)
				stage[i] <= '0;
		end
		else
		begin
			stage[0] <= async_value;
			// Shift towards the output
			for (int i = 1; i < mailbox_pkg::SYNC_STAGES; i++)
				stage[i] <= stage[i-1];
		end
	end

	assign sync_value = stage[mailbox_pkg::SYNC_STAGES-1];

endmodule

// File: source/wb_mailbox_controller.sv
/* Wishbone classic slave for the mailbox registers. Decodes the offset into endpoint
   strobes on the accepting cycle and returns registered read data with a one-cycle ack. */
`timescale 1ns/1ps

module wb_mailbox_controller
(
	input  logic                   rvx_port_02,
	input  logic                   rvx_port_12,

	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  mailbox_pkg::wb_addr_t  wb_adr,
	input  mailbox_pkg::word_t     wb_dat_w,
	output mailbox_pkg::word_t     wb_dat_r,
	output logic                   wb_ack,

	output logic                   take_req,
	output logic                   post_resp,
	output mailbox_pkg::word_t     post_data,
	input  logic                   req_pending,
	input  logic                   resp_unconsumed,
	input  mailbox_pkg::word_t     req_word
);

	mailbox_pkg::wb_state_t state;
	mailbox_pkg::word_t     rd_mux;
	logic                   accept;

	// New access taken only from idle
	assign accept    = (state == mailbox_pkg::wb_idle) && wb_cyc && wb_stb;
	assign take_req  = accept && !wb_we && (wb_adr == mailbox_pkg::REG_REQ_DATA);
	assign post_resp = accept && wb_we && (wb_adr == mailbox_pkg::REG_RESP_DATA);
	assign post_data = wb_dat_w;

	always_comb
	begin
		case (wb_adr)
			mailbox_pkg::REG_STATUS:   rd_mux = {30'b0, resp_unconsumed, req_pending};
			mailbox_pkg::REG_REQ_DATA: rd_mux = req_word;
			default:                   rd_mux = '0;
		endcase
	end

	// Ack high for one cycle, then one quiet cycle before idle
	always_ff @(posedge rvx_port_02 or negedge rvx_port_12)
	begin
		if (!rvx_port_12)
		begin
			state    <= mailbox_pkg::wb_idle;
			wb_ack   <= 1'b0;
			wb_dat_r <= '0;
		end
		else if (accept)
		begin
			state    <= mailbox_pkg::wb_ack;
			wb_ack   <= 1'b1;
			wb_dat_r <= wb_we ? '0 : rd_mux;
		end
		else if (state == mailbox_pkg::wb_ack)
		begin
			wb_ack <= 1'b0;
			if (!wb_ack)
				state <= mailbox_pkg::wb_idle;
		end
	end

endmodule
